//--- design/bus_write_ctrl.sv
`timescale 1ns/10ps
module bus_write_ctrl (
  input  logic                              CPU_CKIO,
  input  logic                              arst_n,
  input  logic [memory_pkg::CPU_ADDR_W-1:0] cpu_addr,
  input  logic [memory_pkg::DATA_W-1:0]     cpu_data,
  input  logic                              cpu_cn,
  input  logic                              cpu_we0_n,
  memory_bus_if.ctrl                        bus
);
  import memory_pkg::*;

  logic [CPU_ADDR_W-1:0] addr_q;
  logic [DATA_W-1:0]     data_q;
  logic                  en_q;
  logic                  we_q;
  bus_state_t            state;
  bus_state_t            state_next;

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      en_q <= 1'b0;
      we_q <= 1'b0;
    end else begin
      en_q <= ~cpu_cn;     // Strobes are active low on the bus
      we_q <= ~cpu_we0_n;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    addr_q <= cpu_addr;
    data_q <= cpu_data;
  end

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // A long write-enable period still gives only one pulse
  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (en_q && we_q) begin
          state_next = ST_WRITE;
        end
      end
      ST_WRITE: state_next = ST_HOLD;
      ST_HOLD: begin
        if (!we_q) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

  assign bus.wr     = (state == ST_WRITE);
  assign bus.select = bram_select_t'(addr_q[CPU_ADDR_W-1 -: 2]);  // Top two bits
  assign bus.addr   = addr_q[BUS_ADDR_W-1:0];
  assign bus.data   = data_q;

endmodule

//--- design/controller_regs.sv
`timescale 1ns/10ps
module controller_regs (
  input  logic                              CPU_CKIO,
  input  logic                              arst_n,
  memory_bus_if.target                      bus,
  input  logic [memory_pkg::BUS_ADDR_W-1:0] ctl_rd_addr,
  output logic [memory_pkg::DATA_W-1:0]     ctl_rd_data,
  output logic                              mod_wr_segment,
  output logic                              stm_wr_segment,
  output logic [memory_pkg::STM_PAGE_W-1:0] stm_wr_page
);
  import memory_pkg::*;

  logic [DATA_W-1:0] settings [NUM_SETTINGS];
  logic              wr_en;
  logic              wr_is_settings;
  logic              rd_is_settings;
  logic [DATA_W-1:0] rd_mux;

  assign wr_en = bus.wr && (bus.select == SEL_CONTROLLER);

  // Settings words occupy one aligned block of sixteen
  assign wr_is_settings = (bus.addr[BUS_ADDR_W-1:SETTINGS_IDX_W] ==
                           ADDR_SETTINGS_BASE[BUS_ADDR_W-1:SETTINGS_IDX_W]);
  assign rd_is_settings = (ctl_rd_addr[BUS_ADDR_W-1:SETTINGS_IDX_W] ==
                           ADDR_SETTINGS_BASE[BUS_ADDR_W-1:SETTINGS_IDX_W]);

  always_ff @(posedge CPU_CKIO or negedge arst_n) begin
    if (!arst_n) begin
      mod_wr_segment <= 1'b0;
      stm_wr_segment <= 1'b0;
      stm_wr_page    <= '0;
      for (int i = 0; i < NUM_SETTINGS; i++) begin
        settings[i] <= '0;
      end
    end else if (wr_en) begin
      if (wr_is_settings) begin
        settings[bus.addr[SETTINGS_IDX_W-1:0]] <= bus.data;
      end else begin
        case (bus.addr)
          ADDR_MOD_WR_SEGMENT: mod_wr_segment <= bus.data[0];
          ADDR_STM_WR_SEGMENT: stm_wr_segment <= bus.data[0];
          ADDR_STM_WR_PAGE:    stm_wr_page <= bus.data[STM_PAGE_W-1:0];
          default: ;  // Unmapped, dropped
        endcase
      end
    end
  end

  always_comb begin
    rd_mux = '0;
    if (rd_is_settings) begin
      rd_mux = settings[ctl_rd_addr[SETTINGS_IDX_W-1:0]];
    end else begin
      case (ctl_rd_addr)
        ADDR_MOD_WR_SEGMENT: rd_mux = {{(DATA_W-1){1'b0}}, mod_wr_segment};
        ADDR_STM_WR_SEGMENT: rd_mux = {{(DATA_W-1){1'b0}}, stm_wr_segment};
        ADDR_STM_WR_PAGE:    rd_mux = {{(DATA_W-STM_PAGE_W){1'b0}}, stm_wr_page};
        default:             rd_mux = '0;
      endcase
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    ctl_rd_data <= rd_mux;
  end

endmodule

//--- design/memory_bus_if.sv
`timescale 1ns/10ps
interface memory_bus_if;
  import memory_pkg::*;

  logic                  wr;      // One-cycle write strobe
  bram_select_t          select;
  logic [BUS_ADDR_W-1:0] addr;
  logic [DATA_W-1:0]     data;

  modport ctrl (
    output wr,
    output select,
    output addr,
    output data
  );

  modport target (
    input wr,
    input select,
    input addr,
    input data
  );

endinterface

//--- design/memory_pkg.sv
package memory_pkg;

  // Target picked by the top two bits of the CPU word address
  typedef enum logic [1:0] {
    SEL_CONTROLLER = 2'd0,
    SEL_MOD        = 2'd1,
    SEL_PWE_TABLE  = 2'd2,
    SEL_STM        = 2'd3
  } bram_select_t;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WRITE,
    ST_HOLD
  } bus_state_t;

  localparam int CPU_ADDR_W = 16;  // Word address on the CPU bus
  localparam int DATA_W = 16;
  localparam int BUS_ADDR_W = 14;  // Offset within one target
  localparam int BYTE_W = 8;

  // Controller register map
  localparam logic [BUS_ADDR_W-1:0] ADDR_MOD_WR_SEGMENT = 14'h000;
  localparam logic [BUS_ADDR_W-1:0] ADDR_STM_WR_SEGMENT = 14'h001;
  localparam logic [BUS_ADDR_W-1:0] ADDR_STM_WR_PAGE = 14'h002;
  localparam logic [BUS_ADDR_W-1:0] ADDR_SETTINGS_BASE = 14'h010;
  localparam int NUM_SETTINGS = 16;
  localparam int SETTINGS_IDX_W = $clog2(NUM_SETTINGS);

  // Modulation memory
  localparam int MOD_WORDS = 512;  // Per segment
  localparam int MOD_ADDR_W = $clog2(MOD_WORDS);
  localparam int MOD_IDX_W = MOD_ADDR_W + 1;  // Byte index

  // STM memory
  localparam int STM_PAGE_WORDS = 256;
  localparam int STM_PAGES = 4;
  localparam int STM_OFFSET_W = $clog2(STM_PAGE_WORDS);
  localparam int STM_PAGE_W = $clog2(STM_PAGES);
  localparam int STM_RD_ADDR_W = STM_PAGE_W + STM_OFFSET_W;  // Page and offset
  localparam int STM_SEG_WORDS = STM_PAGES * STM_PAGE_WORDS;

  // PWE table
  localparam int PWE_WORDS = 128;
  localparam int PWE_ADDR_W = $clog2(PWE_WORDS);
  localparam int PWE_IDX_W = PWE_ADDR_W + 1;  // Byte index

endpackage

//--- design/memory_subsystem.sv
`timescale 1ns/10ps
module memory_subsystem (
  input  logic                                 CPU_CKIO,
  input  logic                                 arst_n,
  input  logic [memory_pkg::CPU_ADDR_W-1:0]    cpu_addr,
  input  logic [memory_pkg::DATA_W-1:0]        cpu_data,
  input  logic                                 cpu_cn,
  input  logic                                 cpu_we0_n,
  input  logic [memory_pkg::BUS_ADDR_W-1:0]    ctl_rd_addr,
  output logic [memory_pkg::DATA_W-1:0]        ctl_rd_data,
  input  logic                                 mod_rd_segment,
  input  logic [memory_pkg::MOD_IDX_W-1:0]     mod_rd_idx,
  output logic [memory_pkg::BYTE_W-1:0]        mod_rd_value,
  input  logic                                 stm_rd_segment,
  input  logic [memory_pkg::STM_RD_ADDR_W-1:0] stm_rd_addr,
  output logic [memory_pkg::DATA_W-1:0]        stm_rd_data,
  input  logic [memory_pkg::PWE_IDX_W-1:0]     pwe_rd_idx,
  output logic [memory_pkg::BYTE_W-1:0]        pwe_rd_value
);

  logic                              mod_wr_segment;
  logic                              stm_wr_segment;
  logic [memory_pkg::STM_PAGE_W-1:0] stm_wr_page;

  memory_bus_if mem_bus ();

  bus_write_ctrl u_bus_write_ctrl (
    .CPU_CKIO  (CPU_CKIO),
    .arst_n    (arst_n),
    .cpu_addr  (cpu_addr),
    .cpu_data  (cpu_data),
    .cpu_cn    (cpu_cn),
    .cpu_we0_n (cpu_we0_n),
    .bus       (mem_bus.ctrl)
  );

  controller_regs u_controller_regs (
    .CPU_CKIO       (CPU_CKIO),
    .arst_n         (arst_n),
    .bus            (mem_bus.target),
    .ctl_rd_addr    (ctl_rd_addr),
    .ctl_rd_data    (ctl_rd_data),
    .mod_wr_segment (mod_wr_segment),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page)
  );

  mod_memory u_mod_memory (
    .CPU_CKIO       (CPU_CKIO),
    .bus            (mem_bus.target),
    .mod_wr_segment (mod_wr_segment),
    .mod_rd_segment (mod_rd_segment),
    .mod_rd_idx     (mod_rd_idx),
    .mod_rd_value   (mod_rd_value)
  );

  stm_memory u_stm_memory (
    .CPU_CKIO       (CPU_CKIO),
    .bus            (mem_bus.target),
    .stm_wr_segment (stm_wr_segment),
    .stm_wr_page    (stm_wr_page),
    .stm_rd_segment (stm_rd_segment),
    .stm_rd_addr    (stm_rd_addr),
    .stm_rd_data    (stm_rd_data)
  );

  pwe_table u_pwe_table (
    .CPU_CKIO     (CPU_CKIO),
    .bus          (mem_bus.target),
    .pwe_rd_idx   (pwe_rd_idx),
    .pwe_rd_value (pwe_rd_value)
  );

endmodule

//--- design/mod_memory.sv
`timescale 1ns/10ps
module mod_memory (
  input  logic                             CPU_CKIO,
  memory_bus_if.target                     bus,
  input  logic                             mod_wr_segment,
  input  logic                             mod_rd_segment,
  input  logic [memory_pkg::MOD_IDX_W-1:0] mod_rd_idx,
  output logic [memory_pkg::BYTE_W-1:0]    mod_rd_value
);
  import memory_pkg::*;

  logic [DATA_W-1:0]   mem [2*MOD_WORDS];
  logic [MOD_ADDR_W:0] wr_idx;
  logic [MOD_ADDR_W:0] rd_idx;
  logic [DATA_W-1:0]   rd_word;
  logic                rd_high;

  assign wr_idx = {mod_wr_segment, bus.addr[MOD_ADDR_W-1:0]};  // Offset wraps per segment
  assign rd_idx = {mod_rd_segment, mod_rd_idx[MOD_IDX_W-1:1]};

  always_ff @(posedge CPU_CKIO) begin
    if (bus.wr && (bus.select == SEL_MOD)) begin
      mem[wr_idx] <= bus.data;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_word <= mem[rd_idx];
    rd_high <= mod_rd_idx[0];
  end

  // Even index low byte, odd index high byte
  assign mod_rd_value = rd_high ? rd_word[DATA_W-1:BYTE_W] : rd_word[BYTE_W-1:0];

endmodule

//--- design/pwe_table.sv
`timescale 1ns/10ps
module pwe_table (
  input  logic                             CPU_CKIO,
  memory_bus_if.target                     bus,
  input  logic [memory_pkg::PWE_IDX_W-1:0] pwe_rd_idx,
  output logic [memory_pkg::BYTE_W-1:0]    pwe_rd_value
);
  import memory_pkg::*;

  logic [DATA_W-1:0] mem [PWE_WORDS];
  logic              wr_in_range;
  logic [DATA_W-1:0] rd_word;
  logic              rd_high;

  assign wr_in_range = (bus.addr[BUS_ADDR_W-1:PWE_ADDR_W] == '0);  // Offsets 0 to 127

  always_ff @(posedge CPU_CKIO) begin
    if (bus.wr && (bus.select == SEL_PWE_TABLE) && wr_in_range) begin
      mem[bus.addr[PWE_ADDR_W-1:0]] <= bus.data;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    rd_word <= mem[pwe_rd_idx[PWE_IDX_W-1:1]];
    rd_high <= pwe_rd_idx[0];
  end

  assign pwe_rd_value = rd_high ? rd_word[DATA_W-1:BYTE_W] : rd_word[BYTE_W-1:0];

endmodule

//--- design/stm_memory.sv
`timescale 1ns/10ps
module stm_memory (
  input  logic                                 CPU_CKIO,
  memory_bus_if.target                         bus,
  input  logic                                 stm_wr_segment,
  input  logic [memory_pkg::STM_PAGE_W-1:0]    stm_wr_page,
  input  logic                                 stm_rd_segment,
  input  logic [memory_pkg::STM_RD_ADDR_W-1:0] stm_rd_addr,
  output logic [memory_pkg::DATA_W-1:0]        stm_rd_data
);
  import memory_pkg::*;

  logic [DATA_W-1:0]      mem [2*STM_SEG_WORDS];
  logic [STM_RD_ADDR_W:0] wr_idx;
  logic [STM_RD_ADDR_W:0] rd_idx;

  // Segment, page, offset
  assign wr_idx = {stm_wr_segment, stm_wr_page, bus.addr[STM_OFFSET_W-1:0]};
  assign rd_idx = {stm_rd_segment, stm_rd_addr};  // Page in upper bits of rd addr

  always_ff @(posedge CPU_CKIO) begin
    if (bus.wr && (bus.select == SEL_STM)) begin
      mem[wr_idx] <= bus.data;
    end
  end

  always_ff @(posedge CPU_CKIO) begin
    stm_rd_data <= mem[rd_idx];
  end

endmodule

//--- dv/memory_subsystem_properties.sv
`timescale 1ns/10ps
module memory_subsystem_properties (
  input logic                          CPU_CKIO,
  input logic                          arst_n,
  input logic                          cpu_cn,
  input logic                          cpu_we0_n,
  input logic                          wr,
  input memory_pkg::bram_select_t      select,
  input logic [memory_pkg::DATA_W-1:0] data,
  input memory_pkg::bus_state_t        state
);
  import memory_pkg::*;

  wr_single_cycle: assert property (@(posedge CPU_CKIO) disable iff (!arst_n) wr |=> !wr)
    else $error("write strobe stayed high for two cycles");

  // A pulse answers a bus write request sampled two edges earlier
  wr_only_in_write: assert property (
    @(posedge CPU_CKIO) disable iff (!arst_n)
    wr |-> (state == ST_WRITE) && $past(!cpu_cn && !cpu_we0_n, 2))
    else $error("write strobe high outside a requested write");

  // Select and data must be clean whenever a target can latch them
  wr_fields_known: assert property (
    @(posedge CPU_CKIO) disable iff (!arst_n) wr |-> !$isunknown({select, data}))
    else $error("select or data unknown during a write");

endmodule

bind bus_write_ctrl memory_subsystem_properties u_properties (
  .CPU_CKIO  (CPU_CKIO),
  .arst_n    (arst_n),
  .cpu_cn    (cpu_cn),
  .cpu_we0_n (cpu_we0_n),
  .wr        (bus.wr),
  .select    (bus.select),
  .data      (bus.data),
  .state     (state)
);

//--- dv/memory_subsystem_testdata.txt
# W target offset data, or L target offset data_first data_late (six-cycle write strobe)
# C name port addr count segment expected; targets 0 ctl 1 mod 2 pwe 3 stm, count/segment decimal
C reset_steering ctl 0000 3 0 0000
C reset_settings ctl 0010 16 0 0000
W 2 0000 0201
W 2 0010 a55a
W 2 0040 7f80
W 2 007f fffe
W 0 0010 1234
W 0 001f beef
W 0 0005 dead
C settings_first ctl 0010 1 0 1234
C settings_last ctl 001f 1 0 beef
C unmapped_read ctl 0005 1 0 0000
C unmapped_no_effect ctl 0000 3 0 0000
W 1 0003 a1b2
W 0 0000 0001
W 1 0003 c3d4
W 1 0205 5566
C mod_seg0_even mod 0006 1 0 00b2
C mod_seg0_odd mod 0007 1 0 00a1
C mod_seg1_even mod 0006 1 1 00d4
C mod_seg1_odd mod 0007 1 1 00c3
C mod_wrap_even mod 000a 1 1 0066
C mod_wrap_odd mod 000b 1 1 0055
W 3 0010 1111
W 0 0002 0002
W 3 0010 2222
W 0 0001 0001
W 0 0002 0003
W 3 0110 3333
C stm_page_reg ctl 0002 1 0 0003
C stm_seg0_page0 stm 0010 1 0 1111
C stm_seg0_page2 stm 0210 1 0 2222
C stm_seg1_page3 stm 0310 1 1 3333
C pwe_first_low pwe 0000 1 0 0001
C pwe_first_high pwe 0001 1 0 0002
C pwe_shared_low pwe 0020 1 0 005a
C pwe_shared_high pwe 0021 1 0 00a5
C pwe_mid_low pwe 0080 1 0 0080
C pwe_mid_high pwe 0081 1 0 007f
C pwe_last_high pwe 00ff 1 0 00ff
L 0 0013 0bad 0f00
C strobe_once_ctl ctl 0013 1 0 0bad
L 3 0020 abcd 9999
C strobe_once_stm stm 0320 1 1 abcd

//--- dv/tb_memory_subsystem.sv
`timescale 1ns/10ps
module tb_memory_subsystem;
  import memory_pkg::*;

  localparam string DATA_FILE = "dv/memory_subsystem_testdata.txt";
  localparam int CLK_HALF = 20;

  logic                     CPU_CKIO;
  logic                     arst_n;
  logic [CPU_ADDR_W-1:0]    cpu_addr;
  logic [DATA_W-1:0]        cpu_data;
  logic                     cpu_cn;
  logic                     cpu_we0_n;
  logic [BUS_ADDR_W-1:0]    ctl_rd_addr;
  logic [DATA_W-1:0]        ctl_rd_data;
  logic                     mod_rd_segment;
  logic [MOD_IDX_W-1:0]     mod_rd_idx;
  logic [BYTE_W-1:0]        mod_rd_value;
  logic                     stm_rd_segment;
  logic [STM_RD_ADDR_W-1:0] stm_rd_addr;
  logic [DATA_W-1:0]        stm_rd_data;
  logic [PWE_IDX_W-1:0]     pwe_rd_idx;
  logic [BYTE_W-1:0]        pwe_rd_value;

  string lines[$];
  int    pass_count;
  int    fail_count;
  int    cycle_count;
  int    cycle_limit = 100;

  memory_subsystem uut (
    .CPU_CKIO       (CPU_CKIO),
    .arst_n         (arst_n),
    .cpu_addr       (cpu_addr),
    .cpu_data       (cpu_data),
    .cpu_cn         (cpu_cn),
    .cpu_we0_n      (cpu_we0_n),
    .ctl_rd_addr    (ctl_rd_addr),
    .ctl_rd_data    (ctl_rd_data),
    .mod_rd_segment (mod_rd_segment),
    .mod_rd_idx     (mod_rd_idx),
    .mod_rd_value   (mod_rd_value),
    .stm_rd_segment (stm_rd_segment),
    .stm_rd_addr    (stm_rd_addr),
    .stm_rd_data    (stm_rd_data),
    .pwe_rd_idx     (pwe_rd_idx),
    .pwe_rd_value   (pwe_rd_value)
  );

  initial begin
    CPU_CKIO = 1'b0;
    forever #CLK_HALF CPU_CKIO = ~CPU_CKIO;
  end

  always @(posedge CPU_CKIO) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
      $display("*** TEST FAILED ***");
      $finish;
    end
  end

  // Called and returns on a falling edge; late data replaces the first after two strobe cycles
  task automatic bus_write(input logic [1:0] target, input logic [BUS_ADDR_W-1:0] offset,
                           input logic [DATA_W-1:0] data_first,
                           input logic [DATA_W-1:0] data_late, input int we_cycles);
    cpu_addr = {target, offset};
    cpu_data = data_first;
    cpu_cn   = 1'b0;
    @(negedge CPU_CKIO);
    cpu_we0_n = 1'b0;
    for (int i = 0; i < we_cycles; i++) begin
      if (i == 2) begin
        cpu_data = data_late;
      end
      @(negedge CPU_CKIO);
    end
    cpu_we0_n = 1'b1;
    cpu_cn    = 1'b1;
    @(negedge CPU_CKIO);  // Idle cycle between strobes
  endtask

  task automatic drive_read(input string port, input logic [31:0] addr, input int seg);
    if (port == "ctl") begin
      ctl_rd_addr = addr[BUS_ADDR_W-1:0];
    end else if (port == "mod") begin
      mod_rd_segment = seg[0];
      mod_rd_idx     = addr[MOD_IDX_W-1:0];
    end else if (port == "stm") begin
      stm_rd_segment = seg[0];
      stm_rd_addr    = addr[STM_RD_ADDR_W-1:0];
    end else begin
      pwe_rd_idx = addr[PWE_IDX_W-1:0];
    end
  endtask

  function automatic logic [DATA_W-1:0] sample_read(input string port);
    if (port == "ctl") return ctl_rd_data;
    if (port == "mod") return {8'h00, mod_rd_value};
    if (port == "stm") return stm_rd_data;
    return {8'h00, pwe_rd_value};
  endfunction

  task automatic read_check(input string name, input string port, input logic [31:0] addr,
                            input int count, input int seg, input logic [DATA_W-1:0] expected);
    logic [DATA_W-1:0] actual;
    int                errors;
    errors = 0;
    for (int i = 0; i < count; i++) begin
      drive_read(port, addr + i, seg);
      @(negedge CPU_CKIO);  // One-cycle read latency
      actual = sample_read(port);
      if (actual !== expected) begin
        $display("** Error %s: address %h expected %h, actual %h", name, addr + i, expected,
                 actual);
        errors++;
      end
    end
    if (errors == 0) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s with %0d mismatches", name, errors);
    end
  endtask

  task automatic run_command(input string line);
    string       cmd;
    string       name;
    string       port;
    int          target;
    int          count;
    int          seg;
    int          n;
    logic [31:0] addr;
    logic [31:0] data_first;
    logic [31:0] data_late;
    n = $sscanf(line, "%s", cmd);
    if (cmd == "W") begin
      n = $sscanf(line, "%s %d %h %h", cmd, target, addr, data_first);
      if (n == 4) begin
        bus_write(target[1:0], addr[BUS_ADDR_W-1:0], data_first[15:0], data_first[15:0], 2);
        return;
      end
    end else if (cmd == "L") begin
      n = $sscanf(line, "%s %d %h %h %h", cmd, target, addr, data_first, data_late);
      if (n == 5) begin
        bus_write(target[1:0], addr[BUS_ADDR_W-1:0], data_first[15:0], data_late[15:0], 6);
        return;
      end
    end else if (cmd == "C") begin
      n = $sscanf(line, "%s %s %s %h %d %d %h", cmd, name, port, addr, count, seg, data_first);
      if (n == 7 && (port == "ctl" || port == "mod" || port == "stm" || port == "pwe")) begin
        read_check(name, port, addr, count, seg, data_first[15:0]);
        return;
      end
    end
    $display("Test data line could not be understood: %s", line);
    fail_count++;
  endtask

  task automatic load_test_data();
    int    fd;
    int    r;
    string line;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("The test data file %s could not be opened", DATA_FILE);
      fail_count++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      r = $fgets(line, fd);
      if (r > 0 && line.len() > 1 && line.getc(0) != "#") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
  endtask

  initial begin
    arst_n         = 1'b0;
    cpu_addr       = '0;
    cpu_data       = '0;
    cpu_cn         = 1'b1;
    cpu_we0_n      = 1'b1;
    ctl_rd_addr    = '0;
    mod_rd_segment = 1'b0;
    mod_rd_idx     = '0;
    stm_rd_segment = 1'b0;
    stm_rd_addr    = '0;
    pwe_rd_idx     = '0;
    pass_count     = 0;
    fail_count     = 0;
    cycle_count    = 0;
    load_test_data();
    cycle_limit = 12 * lines.size() + 100;
    repeat (10) @(negedge CPU_CKIO);
    arst_n = 1'b1;
    @(negedge CPU_CKIO);
    foreach (lines[k]) begin
      run_command(lines[k]);
    end
    $display("Tests finished: %0d passed, %0d failed", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

//--- memory_subsystem.f
design/memory_pkg.sv
design/memory_bus_if.sv
design/bus_write_ctrl.sv
design/controller_regs.sv
design/mod_memory.sv
design/stm_memory.sv
design/pwe_table.sv
design/memory_subsystem.sv
dv/memory_subsystem_properties.sv
dv/tb_memory_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the memory subsystem testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_memory_subsystem -Mdir obj_dir -f memory_subsystem.f
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_memory_subsystem > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qF "*** TEST PASSED ***" "$LOG"; then
  exit 0
fi
exit 1
